// ==== logic/prim_render_pkg.sv ====
// ######################################
// Shared definitions for the primitive renderer.
// Holds the command opcodes, the data widths, the screen
// geometry and the APB register map. Modules import it
// inside their bodies.
// ######################################

package prim_render_pkg;

    localparam int COORD_W = 12;                // signed pixel coordinate width

    typedef logic signed [COORD_W-1:0] coord_t;
    typedef logic [7:0]                color_t; // palette index
    typedef logic [15:0]               vram_addr_t;
    typedef logic [15:0]               vram_data_t;
    typedef logic [3:0]                vram_mask_t; // one bit per nibble
    typedef logic [15:0]               cmd_word_t;  // opcode in [15:12], arg in [11:0]

    // command word opcodes
    typedef enum logic [3:0] {
        OP_COORD_X0    = 4'h0,
        OP_COORD_Y0    = 4'h1,
        OP_COORD_X1    = 4'h2,
        OP_COORD_Y1    = 4'h3,
        OP_COLOR       = 4'h8,
        OP_DEST_ADDR   = 4'h9,
        OP_DEST_HEIGHT = 4'hA,
        OP_EXECUTE     = 4'hF
    } opcode_t;

    localparam logic [3:0] EXEC_FILLED_RECT = 4'd0;    // execute code in arg [3:0]
    localparam logic [3:0] EXEC_FILLED_TRI  = 4'd1;

    // display geometry
    localparam int VISIBLE_WIDTH  = 640;
    localparam int VISIBLE_HEIGHT = 480;
    localparam int PIX_WIDTH      = VISIBLE_WIDTH / 2;  // bitmap pixels per line
    localparam int WORDS_PER_LINE = VISIBLE_WIDTH / 4;  // two pixels per word
    localparam int DEFAULT_HEIGHT = VISIBLE_HEIGHT / 2;

    // even x is the high byte of the word
    localparam vram_mask_t MASK_EVEN = 4'b1100;
    localparam vram_mask_t MASK_ODD  = 4'b0011;

    // APB register offsets
    localparam logic [3:0] APB_ADDR_CMD    = 4'h0;
    localparam logic [3:0] APB_ADDR_STATUS = 4'h4;

endpackage

// ==== logic/draw_cmd_if.sv ====
// ######################################
// Rectangle job as latched by the command registers.
// The rasterizer takes the corners and start and
// reports busy and done. The pixel writer takes the
// colour and the destination.
// ######################################

`timescale 1ns/1ps

interface draw_cmd_if;
    import prim_render_pkg::*;

    logic       start;          // one cycle pulse
    coord_t     x0, y0, x1, y1;
    color_t     color;
    vram_addr_t dest_addr;
    coord_t     dest_height;
    logic       busy;
    logic       done;           // one cycle pulse at job end

    modport regs   (output start, x0, y0, x1, y1, color, dest_addr, dest_height,
                    input busy);
    modport raster (input start, x0, y0, x1, y1, output busy, done);
    modport writer (input color, dest_addr, dest_height);

endinterface

// ==== logic/pixel_if.sv ====
// ######################################
// Pixel stream from the rasterizer to the pixel writer.
// A pixel moves on a cycle with valid and ready both
// high. The source holds x, y and last while stalled.
// ######################################

`timescale 1ns/1ps

interface pixel_if;
    import prim_render_pkg::*;

    logic   valid;
    logic   ready;
    coord_t x;
    coord_t y;
    logic   last;      // final pixel of the job

    modport source (output valid, x, y, last, input ready);
    modport sink   (input valid, x, y, last, output ready);

endinterface

// ==== logic/apb_cmd_regs.sv ====
// ######################################
// APB slave for the renderer command port.
// Writes to the command offset load the staging
// registers or execute a job. An execute during a
// job waits on pready until the job ends. The status
// offset reads busy in bit 0.
// ######################################

`timescale 1ns/1ps

module apb_cmd_regs (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [3:0]                  paddr_i,
    input  prim_render_pkg::cmd_word_t  pwdata_i,
    output prim_render_pkg::vram_data_t prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    draw_cmd_if.regs                    cmd
);
    import prim_render_pkg::*;

    opcode_t    opcode;
    logic       access;
    logic       sel_cmd;
    logic       sel_status;
    logic       is_exec;
    logic       exec_stall;
    logic       cmd_wr;
    logic       start_rect;

    coord_t     x0_q, y0_q, x1_q, y1_q;     // staging copies
    color_t     color_q;
    vram_addr_t dest_addr_q;
    coord_t     dest_height_q;

    always_comb begin
        access     = psel_i && penable_i;
        sel_cmd    = (paddr_i == APB_ADDR_CMD);
        sel_status = (paddr_i == APB_ADDR_STATUS);
        opcode     = opcode_t'(pwdata_i[15:12]);
        is_exec    = pwrite_i && sel_cmd && (opcode == OP_EXECUTE);
        exec_stall = is_exec && (cmd.busy || cmd.start); // job running or about to
        pready_o   = !(access && exec_stall);
        pslverr_o  = access && !(sel_cmd || sel_status);
        cmd_wr     = access && pwrite_i && sel_cmd && !exec_stall;

        prdata_o = '0;
        if (access && !pwrite_i && sel_status) begin
            prdata_o[0] = cmd.busy;
        end

        // triangle and unknown codes start nothing
        start_rect = cmd_wr && is_exec && (pwdata_i[3:0] == EXEC_FILLED_RECT);
    end

    // base address and height of the destination surface
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dest_addr_q   <= '0;
            dest_height_q <= coord_t'(DEFAULT_HEIGHT);
        end else if (cmd_wr) begin
            case (opcode)
                OP_DEST_ADDR:   dest_addr_q   <= {pwdata_i[11:0], 4'b0000};
                OP_DEST_HEIGHT: dest_height_q <= pwdata_i[11:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_wr) begin
            case (opcode)
                OP_COORD_X0: x0_q    <= pwdata_i[11:0];
                OP_COORD_Y0: y0_q    <= pwdata_i[11:0];
                OP_COORD_X1: x1_q    <= pwdata_i[11:0];
                OP_COORD_Y1: y1_q    <= pwdata_i[11:0];
                OP_COLOR:    color_q <= pwdata_i[7:0];
                default: begin
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cmd.start <= 1'b0;
        end else begin
            cmd.start <= start_rect;    // lands one cycle after the access
        end
    end

    // job values stay frozen until the next accepted execute
    always_ff @(posedge clk) begin
        if (start_rect) begin
            cmd.x0          <= x0_q;
            cmd.y0          <= y0_q;
            cmd.x1          <= x1_q;
            cmd.y1          <= y1_q;
            cmd.color       <= color_q;
            cmd.dest_addr   <= dest_addr_q;
            cmd.dest_height <= dest_height_q;
        end
    end

endmodule

// ==== logic/rect_fill.sv ====
// ######################################
// Filled rectangle rasterizer.
// On start it sorts the two corners, then offers one
// pixel per cycle in raster order while the writer is
// ready. It ends the job once the writer has drained.
// ######################################

`timescale 1ns/1ps

module rect_fill #(
    parameter int CORD_W = 12
) (
    input  logic       clk,
    input  logic       reset_i,
    draw_cmd_if.raster cmd,
    pixel_if.source    pix,
    input  logic       writer_idle_i
);
    import prim_render_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        INIT,
        DRAW,
        WAIT_DONE
    } rect_state_t;

    rect_state_t              state;
    logic signed [CORD_W-1:0] x_min;
    logic signed [CORD_W-1:0] x_max;
    logic signed [CORD_W-1:0] y_max;
    logic signed [CORD_W-1:0] x_cnt;
    logic signed [CORD_W-1:0] y_cnt;
    logic                     row_end;
    logic                     accept;

    always_comb begin
        row_end   = (x_cnt == x_max);
        pix.valid = (state == DRAW);
        pix.x     = x_cnt;
        pix.y     = y_cnt;
        pix.last  = row_end && (y_cnt == y_max);    // bottom right corner
        accept    = pix.valid && pix.ready;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= IDLE;
            cmd.busy <= 1'b0;
            cmd.done <= 1'b0;
        end else begin
            cmd.done <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd.start) begin
                        state    <= INIT;
                        cmd.busy <= 1'b1;
                    end
                end
                INIT: begin
                    state <= DRAW;
                end
                DRAW: begin
                    if (accept && pix.last) begin
                        state <= WAIT_DONE;
                    end
                end
                WAIT_DONE: begin
                    if (writer_idle_i) begin    // last write has left the writer
                        state    <= IDLE;
                        cmd.busy <= 1'b0;
                        cmd.done <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // bounds load in INIT and counters step on accepted pixels
    always_ff @(posedge clk) begin
        if (state == INIT) begin
            x_min <= (cmd.x0 < cmd.x1) ? cmd.x0 : cmd.x1;
            x_max <= (cmd.x0 < cmd.x1) ? cmd.x1 : cmd.x0;
            y_max <= (cmd.y0 < cmd.y1) ? cmd.y1 : cmd.y0;
            x_cnt <= (cmd.x0 < cmd.x1) ? cmd.x0 : cmd.x1;
            y_cnt <= (cmd.y0 < cmd.y1) ? cmd.y0 : cmd.y1;
        end else if (accept && !pix.last) begin
            if (row_end) begin
                x_cnt <= x_min;                 // wrap to next row
                y_cnt <= y_cnt + CORD_W'(1);
            end else begin
                x_cnt <= x_cnt + CORD_W'(1);
            end
        end
    end

endmodule

// ==== logic/pixel_writer.sv ====
// ######################################
// Pixel writer for the VRAM port.
// Clips each pixel to the visible width and the
// destination height, then registers one nibble
// masked write. The write holds until VRAM takes it.
// ######################################

`timescale 1ns/1ps

module pixel_writer (
    input  logic                         clk,
    input  logic                         reset_i,
    pixel_if.sink                        pix,
    draw_cmd_if.writer                   cmd,
    input  logic                         vram_ready_i,
    output logic                         vram_wr_o,
    output prim_render_pkg::vram_addr_t  vram_addr_o,
    output prim_render_pkg::vram_mask_t  vram_mask_o,
    output prim_render_pkg::vram_data_t  vram_data_o,
    output logic                         idle_o
);
    import prim_render_pkg::*;

    logic       wr_q;
    vram_addr_t addr_q;
    vram_mask_t mask_q;
    vram_data_t data_q;
    logic       x_in;
    logic       y_in;
    logic       in_range;
    vram_addr_t row_base;
    vram_addr_t pix_addr;

    always_comb begin
        x_in     = (pix.x >= 0) && (pix.x < PIX_WIDTH);
        y_in     = (pix.y >= 0) && ($unsigned(pix.y) < $unsigned(cmd.dest_height));
        in_range = x_in && y_in;
        row_base = vram_addr_t'(WORDS_PER_LINE) * {4'b0000, pix.y};
        pix_addr = cmd.dest_addr + row_base + {5'b00000, pix.x[11:1]};  // two pixels per word
        pix.ready = !wr_q || vram_ready_i;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_q <= 1'b0;
        end else if (pix.ready) begin
            wr_q <= pix.valid && in_range;   // clipped pixels just vanish
        end
    end

    always_ff @(posedge clk) begin
        if (pix.ready && pix.valid && in_range) begin
            addr_q <= pix_addr;
            mask_q <= pix.x[0] ? MASK_ODD : MASK_EVEN;
            data_q <= {cmd.color, cmd.color};
        end
    end

    always_comb begin
        vram_wr_o   = wr_q;
        vram_addr_o = addr_q;
        vram_mask_o = mask_q;
        vram_data_o = data_q;
        idle_o      = !wr_q;
    end

endmodule

// ==== logic/prim_render_top.sv ====
// ######################################
// Primitive renderer top level.
// APB command port on one side and a masked VRAM
// write port on the other. busy is high while a
// rectangle job is running.
// ######################################

`timescale 1ns/1ps

module prim_render_top (
    input  logic                        clk,
    input  logic                        reset_i,
    input  logic                        psel_i,
    input  logic                        penable_i,
    input  logic                        pwrite_i,
    input  logic [3:0]                  paddr_i,
    input  prim_render_pkg::cmd_word_t  pwdata_i,
    output prim_render_pkg::vram_data_t prdata_o,
    output logic                        pready_o,
    output logic                        pslverr_o,
    output logic                        vram_wr_o,
    output prim_render_pkg::vram_addr_t vram_addr_o,
    output prim_render_pkg::vram_mask_t vram_mask_o,
    output prim_render_pkg::vram_data_t vram_data_o,
    input  logic                        vram_ready_i,
    output logic                        busy_o
);
    import prim_render_pkg::*;

    logic writer_idle;

    draw_cmd_if cmd ();
    pixel_if    pix ();

    apb_cmd_regs u_cmd_regs (
        .clk       (clk),
        .reset_i   (reset_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .cmd       (cmd.regs)
    );

    rect_fill #(.CORD_W(COORD_W)) u_rect_fill (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd           (cmd.raster),
        .pix           (pix.source),
        .writer_idle_i (writer_idle)
    );

    pixel_writer u_pixel_writer (
        .clk          (clk),
        .reset_i      (reset_i),
        .pix          (pix.sink),
        .cmd          (cmd.writer),
        .vram_ready_i (vram_ready_i),
        .vram_wr_o    (vram_wr_o),
        .vram_addr_o  (vram_addr_o),
        .vram_mask_o  (vram_mask_o),
        .vram_data_o  (vram_data_o),
        .idle_o       (writer_idle)
    );

    assign busy_o = cmd.busy;

endmodule

// ==== tb/prim_render_checker.sv ====
// ########################################
// Protocol assertions for the primitive renderer.
// Bound into the top level by the testbench. Covers
// the pixel and VRAM handshakes, the done pulse and
// the APB ready rule.
// ########################################

`timescale 1ns/1ps

module prim_render_checker (
    input logic        clk,
    input logic        reset_i,
    input logic        psel_i,
    input logic        penable_i,
    input logic        pready_i,
    input logic        pix_valid_i,
    input logic        pix_ready_i,
    input logic [24:0] pix_i,           // x, y and last
    input logic        vram_wr_i,
    input logic        vram_ready_i,
    input logic [35:0] vram_out_i,      // addr, mask and data
    input logic        done_i
);

    pixel_hold: assert property (@(posedge clk) disable iff (reset_i)
        pix_valid_i && !pix_ready_i |=> pix_valid_i && $stable(pix_i))
        else $error("pixel changed while stalled");

    vram_hold: assert property (@(posedge clk) disable iff (reset_i)
        vram_wr_i && !vram_ready_i |=> vram_wr_i && $stable(vram_out_i))
        else $error("VRAM write changed while stalled");

    done_pulse: assert property (@(posedge clk) disable iff (reset_i)
        done_i |=> !done_i)
        else $error("done held for more than one cycle");

    // wait states only inside an access phase
    ready_idle: assert property (@(posedge clk) disable iff (reset_i)
        !(psel_i && penable_i) |-> pready_i)
        else $error("pready low outside an access phase");

endmodule

// ==== tb/prim_render_tb.sv ====
// ########################################
// Testbench for the primitive renderer.
// Programs rectangle jobs from a table over APB, predicts
// the VRAM writes with a reference model and checks every
// accepted write. Stops at the first mismatch or timeout.
// ########################################

`timescale 1ns/1ps

module prim_render_tb;
    import prim_render_pkg::*;

    typedef struct {
        int x0, y0, x1, y1;
        int color;
        int dest;           // destination word before the shift by four
        int height;
        bit stall;
    } job_t;

    localparam int NUM_JOBS = 8;    // last two run overlapped

    job_t jobs [NUM_JOBS] = '{
        '{13, 6, 4, 2, 'h5A, 'h010, 240, 1'b0},         // reversed corners
        '{-3, 0, 2, 3, 'hC3, 'h000, 240, 1'b0},         // crosses x = 0
        '{316, 10, 323, 12, 'h21, 'h100, 240, 1'b0},    // crosses right edge
        '{20, 12, 25, 5, 'h7E, 'h200, 8, 1'b0},         // reduced height
        '{400, 0, 405, 1, 'h11, 'h000, 240, 1'b0},      // fully off screen
        '{111, 57, 100, 50, 'h99, 'h040, 240, 1'b1},    // random VRAM stalls
        '{0, 100, 15, 103, 'hE7, 'h080, 240, 1'b0},
        '{54, 23, 50, 20, 'h3C, 'h300, 100, 1'b0}
    };

    logic       clk;
    logic       reset_i;
    logic       psel_i, penable_i, pwrite_i;
    logic [3:0] paddr_i;
    cmd_word_t  pwdata_i;
    vram_data_t prdata_o;
    logic       pready_o, pslverr_o, vram_wr_o, busy_o;
    vram_addr_t vram_addr_o;
    vram_mask_t vram_mask_o;
    vram_data_t vram_data_o;
    logic        vram_ready_i = 1'b1;
    logic        stall_en = 1'b0;
    logic [31:0] lfsr = 32'h8428e0b9;
    int          cycles = 0;
    int          limit;
    vram_addr_t  exp_addr [$];
    vram_mask_t  exp_mask [$];
    vram_data_t  exp_data [$];

    prim_render_top dut_i (.*);

    bind prim_render_top prim_render_checker u_checker (
        .clk(clk), .reset_i(reset_i), .psel_i(psel_i), .penable_i(penable_i),
        .pready_i(pready_o), .pix_valid_i(pix.valid), .pix_ready_i(pix.ready),
        .pix_i({pix.x, pix.y, pix.last}), .vram_wr_i(vram_wr_o),
        .vram_ready_i(vram_ready_i),
        .vram_out_i({vram_addr_o, vram_mask_o, vram_data_o}), .done_i(cmd.done)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};     // taps 32 22 2 1
    endfunction

    always @(negedge clk) begin
        if (stall_en) begin
            lfsr = lfsr_step(lfsr);
            vram_ready_i = lfsr[0];
        end else begin
            vram_ready_i = 1'b1;
        end
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_addr(input string name, input vram_addr_t act, input vram_addr_t exp);
        if (act !== exp)
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, act, exp));
    endtask

    task automatic check_mask(input string name, input vram_mask_t act, input vram_mask_t exp);
        if (act !== exp)
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, act, exp));
    endtask

    task automatic check_data(input string name, input vram_data_t act, input vram_data_t exp);
        if (act !== exp)
            abort_run($sformatf("Error at %0t: %s is %h, expected %h", $time, name, act, exp));
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        if (act !== exp)
            abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, name, act, exp));
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            abort_run($sformatf("timeout, run did not finish in %0d cycles", limit));
    end

    // one expected write per accepted VRAM cycle
    always @(posedge clk) begin
        if (!reset_i && vram_wr_o && vram_ready_i) begin
            if (exp_addr.size() == 0) begin
                abort_run("VRAM write seen while no write was expected");
            end else begin
                check_addr("vram_addr_o", vram_addr_o, exp_addr.pop_front());
                check_mask("vram_mask_o", vram_mask_o, exp_mask.pop_front());
                check_data("vram_data_o", vram_data_o, exp_data.pop_front());
            end
        end
    end

    function automatic int pixel_count(input int i);
        int w;
        int h;
        w = (jobs[i].x1 > jobs[i].x0) ? jobs[i].x1 - jobs[i].x0 : jobs[i].x0 - jobs[i].x1;
        h = (jobs[i].y1 > jobs[i].y0) ? jobs[i].y1 - jobs[i].y0 : jobs[i].y0 - jobs[i].y1;
        return (w + 1) * (h + 1);
    endfunction

    // reference model of raster order, clip and address rule
    task automatic push_expected(input int i, output int count);
        int     x_lo;
        int     x_hi;
        int     y_lo;
        int     y_hi;
        color_t c;
        count = 0;
        c     = color_t'(jobs[i].color);
        x_lo  = (jobs[i].x0 < jobs[i].x1) ? jobs[i].x0 : jobs[i].x1;
        x_hi  = (jobs[i].x0 < jobs[i].x1) ? jobs[i].x1 : jobs[i].x0;
        y_lo  = (jobs[i].y0 < jobs[i].y1) ? jobs[i].y0 : jobs[i].y1;
        y_hi  = (jobs[i].y0 < jobs[i].y1) ? jobs[i].y1 : jobs[i].y0;
        for (int y = y_lo; y <= y_hi; y++) begin
            for (int x = x_lo; x <= x_hi; x++) begin
                if (x >= 0 && x < 320 && y >= 0 && y < jobs[i].height) begin
                    exp_addr.push_back(vram_addr_t'((jobs[i].dest << 4) + y * 160 + x / 2));
                    exp_mask.push_back((x % 2 == 1) ? 4'b0011 : 4'b1100);
                    exp_data.push_back({c, c});
                    count++;
                end
            end
        end
    endtask

    task automatic apb_xfer(input logic wr, input logic [3:0] addr, input cmd_word_t data,
                            output vram_data_t rdata, output logic err, output int waits);
        @(negedge clk);
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = data;
        @(negedge clk);
        penable_i = 1'b1;
        waits     = 0;
        @(posedge clk);
        while (!pready_o) begin
            waits++;
            @(posedge clk);
        end
        rdata = prdata_o;
        err   = pslverr_o;
        @(negedge clk);
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic write_cmd(input opcode_t op, input logic [11:0] arg, output int waits);
        vram_data_t rdata;
        logic       err;
        apb_xfer(1'b1, APB_ADDR_CMD, {op, arg}, rdata, err, waits);
        check_bit("pslverr_o", err, 1'b0);
    endtask

    task automatic program_job(input int i, output int count);
        int w;
        write_cmd(OP_COORD_X0, 12'(jobs[i].x0), w);
        write_cmd(OP_COORD_Y0, 12'(jobs[i].y0), w);
        write_cmd(OP_COORD_X1, 12'(jobs[i].x1), w);
        write_cmd(OP_COORD_Y1, 12'(jobs[i].y1), w);
        write_cmd(OP_COLOR, 12'(jobs[i].color), w);
        write_cmd(OP_DEST_ADDR, 12'(jobs[i].dest), w);
        write_cmd(OP_DEST_HEIGHT, 12'(jobs[i].height), w);
        push_expected(i, count);
        stall_en = jobs[i].stall;
    endtask

    task automatic wait_job();
        while (!busy_o) @(posedge clk);
        while (busy_o) @(posedge clk);
        stall_en = 1'b0;
        if (exp_addr.size() != 0)
            abort_run($sformatf("job ended with %0d expected writes missing", exp_addr.size()));
    endtask

    initial begin
        int         waits;
        int         count;
        vram_data_t rdata;
        logic       err;
        limit = 200;
        for (int i = 0; i < NUM_JOBS; i++)
            limit += 4 * pixel_count(i);
        reset_i   = 1'b1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        check_bit("busy_o", busy_o, 1'b0);
        apb_xfer(1'b0, APB_ADDR_STATUS, '0, rdata, err, waits);
        check_data("prdata_o", rdata, 16'h0000);
        apb_xfer(1'b1, 4'h8, {OP_EXECUTE, 12'h000}, rdata, err, waits);  // bad offset
        check_bit("pslverr_o", err, 1'b1);
        apb_xfer(1'b0, 4'hC, '0, rdata, err, waits);
        check_bit("pslverr_o", err, 1'b1);
        write_cmd(OP_EXECUTE, {8'h00, EXEC_FILLED_TRI}, waits);
        repeat (8) begin
            @(posedge clk);
            check_bit("busy_o", busy_o, 1'b0);
        end
        for (int i = 0; i < NUM_JOBS - 2; i++) begin
            program_job(i, count);
            write_cmd(OP_EXECUTE, {8'h00, EXEC_FILLED_RECT}, waits);
            wait_job();
        end
        // second execute arrives while the first job is drawing
        program_job(NUM_JOBS - 2, count);
        write_cmd(OP_EXECUTE, {8'h00, EXEC_FILLED_RECT}, waits);
        while (!busy_o) @(posedge clk);
        program_job(NUM_JOBS - 1, count);
        apb_xfer(1'b0, APB_ADDR_STATUS, '0, rdata, err, waits);
        check_data("prdata_o", rdata, 16'h0001);
        write_cmd(OP_EXECUTE, {8'h00, EXEC_FILLED_RECT}, waits);
        if (waits == 0)
            abort_run("execute during a busy job was not held on pready");
        if (exp_addr.size() != count)
            abort_run("held execute completed before the first job had drained");
        wait_job();
        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== prim_render.f ====
logic/prim_render_pkg.sv
logic/draw_cmd_if.sv
logic/pixel_if.sv
logic/apb_cmd_regs.sv
logic/rect_fill.sv
logic/pixel_writer.sv
logic/prim_render_top.sv
tb/prim_render_checker.sv
tb/prim_render_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the renderer testbench with Verilator, runs it and checks the log
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f prim_render.f --top-module prim_render_tb -o prim_render_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/prim_render_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS PASSED" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
